// File: sim.f
common/knight_pkg.sv
pwm_capture/pwm_capture.sv
wheel_dynamics/wheel_dynamics.sv
board_model/board_model.sv
rtl/knight_physics.sv
bench/knight_physics_assert.sv
bench/knight_physics_tb.sv

// File: Makefile
# build and run the testbench with Verilator, result taken from sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module knight_physics_tb -f sim.f
	./obj_dir/Vknight_physics_tb > sim.log 2>&1; rc=$$?; cat sim.log; \
	  test $$rc -eq 0 && ! grep -q "Finished with errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/knight_physics_tb.sv
`timescale 1ns/1ps
`default_nettype none

module knight_physics_tb import knight_pkg::*; ();

  // loop limits of the five tests in updates
  localparam int UPDATES = 2 + 40 + 600 + 2500 + 160;
  localparam int TIMEOUT = (UPDATES + 8) * PWM_PERIOD;

  logic clk;
  logic rst_n;
  logic ir_en;
  logic lft_pwm1 = 1'b0;
  logic lft_pwm2 = 1'b0;
  logic rght_pwm1 = 1'b0;
  logic rght_pwm2 = 1'b0;
  logic lft_ir_n, cntr_ir_n, rght_ir_n;
  pose_t pose;
  logic signed [HEAD_BITS-1:0] heading;
  logic phys_vld;

  drive_t req = '0;               // duties asked for by the running test
  drive_t act = '0;               // duties of the current pwm period
  drive_t use_d;
  drive_t duty_q[$];              // one entry per finished period
  logic [PWM_BITS-1:0] cnt;       // follows the capture period counter
  logic [PWM_BITS-1:0] cnt_nxt;
  int cycles = 0;
  int checks = 0;
  int errors = 0;

  // reference model state
  int m_ol, m_or;
  logic signed [HEAD_BITS-1:0] m_head;
  logic [POS_BITS-1:0] m_x, m_y;
  ir_t m_ir;

  knight_physics UUT (
    .clk(clk), .rst_n(rst_n),
    .lft_pwm1(lft_pwm1), .lft_pwm2(lft_pwm2), .rght_pwm1(rght_pwm1), .rght_pwm2(rght_pwm2),
    .ir_en(ir_en),
    .lft_ir_n(lft_ir_n), .cntr_ir_n(cntr_ir_n), .rght_ir_n(rght_ir_n),
    .pose(pose), .heading(heading), .phys_vld(phys_vld)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // pwm lines high for duty counts of each period
  //////////////////////////////////////////////////
  assign cnt_nxt = rst_n ? cnt + 1'b1 : '0;  // counter held at 0 in reset
  assign use_d   = (cnt_nxt == '0) ? req : act;

  always @(posedge clk) begin
    cnt <= cnt_nxt;
    if (cnt_nxt == '0) act <= req;                  // new period picks up the request
    if (rst_n && cnt == PWM_BITS'(PWM_PERIOD - 1)) duty_q.push_back(act);
    lft_pwm1  <= (cnt_nxt < use_d.lft1);
    lft_pwm2  <= (cnt_nxt < use_d.lft2);
    rght_pwm1 <= (cnt_nxt < use_d.rght1);
    rght_pwm2 <= (cnt_nxt < use_d.rght2);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT) begin
      $display("timeout after %0d cycles, tests did not complete", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic int next_omega(input int fwd, input int rev, input int omega);
    int alpha;
    int nxt;
    alpha = fwd - rev - (omega >>> 4) - (omega >>> 6);
    if (alpha > 4095) alpha = 4095;               // 13 bit saturation
    else if (alpha < -4096) alpha = -4096;
    if (alpha > FRICTION_BAND || alpha < -FRICTION_BAND) begin
      nxt = omega + (alpha >>> 3);
      if (nxt > OMEGA_MAX) nxt = OMEGA_MAX;
      else if (nxt < -OMEGA_MAX) nxt = -OMEGA_MAX;
    end else begin
      nxt = omega - (omega >>> 6);                 // friction only
    end
    return nxt;
  endfunction

  function automatic compass_e sector_of(input logic [11:0] h);
    if (h <= 12'h048) return north_w;
    if (h >= 12'hFB8) return north_e;
    if (h >= 12'h3B8 && h <= 12'h448) return west;
    if (h >= 12'h7B8 && h <= 12'h7FF) return south_w;
    if (h >= 12'h800 && h <= 12'h848) return south_e;
    if (h >= 12'hBB8 && h <= 12'hC48) return east;
    return skew;
  endfunction

  function automatic logic in_window(input logic [11:0] c);
    return (c > LINE_A_LO && c < LINE_A_HI) || (c > LINE_B_LO && c < LINE_B_HI);
  endfunction

  task automatic advance_model(input drive_t d);
    int yaw, hsum, sum, stp;
    logic [11:0] lat;
    logic mov, fst, hi_side, lo_side;
    compass_e sec;
    m_ol = next_omega(d.lft1, d.lft2, m_ol);
    m_or = next_omega(d.rght1, d.rght2, m_or);
    yaw  = (m_or >>> 1) - (m_ol >>> 1);
    hsum = int'(m_head) + (yaw >>> 7) + (yaw >>> 8) - (yaw >>> 12) - (yaw >>> 13) - (yaw >>> 14);
    m_head = hsum[19:0];                            // heading wraps at 20 bits
    sec = sector_of(m_head[19:8]);
    sum = m_ol + m_or;
    stp = (sum >> 13) & 15;                         // bits 16..13 of the sum
    mov = (m_ol > MOVE_MIN) && (m_or > MOVE_MIN);
    fst = (sum > RAIL_SPEED);
    if (mov) begin
      case (sec)
        north_w, north_e: m_y = m_y + POS_BITS'(stp);
        south_w, south_e: m_y = m_y - POS_BITS'(stp);
        west:             m_x = m_x - POS_BITS'(stp);
        east:             m_x = m_x + POS_BITS'(stp);
        default:          m_x = m_x;
      endcase
    end
    lat = (sec == west || sec == east) ? m_y[11:0] : m_x[11:0];
    hi_side = fst && (lat > RAIL_HI);
    lo_side = fst && (lat < RAIL_LO);
    m_ir = IR_OFF;
    m_ir.cntr_n = !(in_window(m_x[11:0]) || in_window(m_y[11:0]));
    if (mov && (sec == north_w || sec == north_e || sec == west)) begin
      m_ir.rght_n = !hi_side;
      m_ir.lft_n  = !lo_side;
    end else if (mov && sec != skew) begin       // facing back
      m_ir.lft_n  = !hi_side;
      m_ir.rght_n = !lo_side;
    end
    if ((sec == north_w || sec == north_e) && m_y > BORDER_Y) m_ir = IR_ALL;
  endtask

  task automatic compare_outputs();
    ir_t exp_ir;
    exp_ir = ir_en ? m_ir : IR_OFF;                // emitters off so nothing seen
    checks++;
    if (pose.x !== m_x || pose.y !== m_y) begin
      errors++;
      $display("mismatch at %0t: pose %h,%h expected %h,%h", $time, pose.x, pose.y, m_x, m_y);
    end
    if (heading !== m_head) begin
      errors++;
      $display("mismatch at %0t: heading %h expected %h", $time, heading, m_head);
    end
    if ({lft_ir_n, cntr_ir_n, rght_ir_n} !== exp_ir) begin
      errors++;
      $display("mismatch at %0t: ir %b expected %b", $time,
               {lft_ir_n, cntr_ir_n, rght_ir_n}, exp_ir);
    end
  endtask

  // wait for the next phys_vld then step the model with that period's duties
  task automatic wait_update();
    drive_t d;
    @(posedge clk);
    while (phys_vld !== 1'b1) @(posedge clk);
    if (duty_q.size() == 0) begin
      errors++;
      $display("update at %0t arrived with no finished pwm period", $time);
    end else begin
      d = duty_q.pop_front();
      advance_model(d);
      compare_outputs();
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic check_reset();
    checks++;
    if ({lft_ir_n, cntr_ir_n, rght_ir_n} !== 3'b111 || pose.x !== START_X
        || pose.y !== START_Y || heading !== '0) begin
      errors++;
      $display("mismatch at %0t: reset state ir %b pose %h heading %h", $time,
               {lft_ir_n, cntr_ir_n, rght_ir_n}, pose, heading);
    end
    repeat (2) wait_update();                       // zero duties so nothing moves
    checks++;
    if (pose.x !== START_X || pose.y !== START_Y || heading !== '0) begin
      errors++;
      $display("mismatch at %0t: idle robot moved to %h heading %h", $time, pose, heading);
    end
  endtask

  task automatic drive_balanced();
    logic [PWM_BITS-1:0] d;
    logic [POS_BITS-1:0] x0, y0;
    d  = PWM_BITS'(1400 + $urandom % 600);
    req <= '{lft1: d, lft2: '0, rght1: d, rght2: '0};
    x0 = pose.x;
    y0 = pose.y;
    repeat (40) begin
      wait_update();
      checks++;
      if (heading !== '0 || pose.x !== x0) begin
        errors++;
        $display("mismatch at %0t: straight run heading %h x %h", $time, heading, pose.x);
      end
    end
    if (pose.y <= y0) begin
      errors++;
      $display("balanced drive never moved the robot north");
    end
  endtask

  task automatic cross_line();
    logic [PWM_BITS-1:0] d;
    bit seen, done;
    int n;
    d = PWM_BITS'(1700 + $urandom % 300);
    req <= '{lft1: d, lft2: '0, rght1: d, rght2: '0};
    seen = 0;
    done = 0;
    n = 0;
    while (!done && n < 600) begin
      wait_update();
      n++;
      if (in_window(m_y[11:0]) && !seen) begin
        seen = 1;
        ir_en <= 1'b0;                              // emitters off for one update
        wait_update();
        n++;
        checks++;
        if ({lft_ir_n, cntr_ir_n, rght_ir_n} !== 3'b111) begin
          errors++;
          $display("mismatch at %0t: ir %b with emitters off", $time,
                   {lft_ir_n, cntr_ir_n, rght_ir_n});
        end
        ir_en <= 1'b1;
      end else if (seen && !in_window(m_y[11:0])) begin
        done = 1;
      end
    end
    if (!done) begin
      errors++;
      $display("forward run never crossed a centre line");
    end
  endtask

  task automatic reach_border();
    int n;
    req <= '{lft1: 11'd2000, lft2: '0, rght1: 11'd2000, rght2: '0};
    n = 0;
    while (m_y <= BORDER_Y && n < 2500) begin
      wait_update();
      n++;
    end
    checks++;
    if (m_y <= BORDER_Y) begin
      errors++;
      $display("robot never got past the north border");
    end else if ({lft_ir_n, cntr_ir_n, rght_ir_n} !== 3'b000) begin
      errors++;
      $display("mismatch at %0t: ir %b at the border", $time, {lft_ir_n, cntr_ir_n, rght_ir_n});
    end
  endtask

  task automatic pivot_in_place();
    logic [PWM_BITS-1:0] d_back, d_fwd;
    logic signed [HEAD_BITS-1:0] head0;
    pose_t prev;
    d_back = PWM_BITS'(1200 + $urandom % 800);
    d_fwd  = PWM_BITS'(1200 + $urandom % 800);
    req <= '{lft1: '0, lft2: d_back, rght1: d_fwd, rght2: '0};
    head0 = heading;
    repeat (160) begin
      prev = pose;
      wait_update();
      checks++;
      if (!(m_ol > MOVE_MIN && m_or > MOVE_MIN) && pose !== prev) begin
        errors++;
        $display("mismatch at %0t: pivoting robot moved from %h to %h", $time, prev, pose);
      end
    end
    if (heading === head0) begin
      errors++;
      $display("pivot left the heading where it was");
    end
  endtask

  initial begin
    void'($urandom(26));
    rst_n  = 1'b0;
    ir_en  = 1'b1;
    m_ol   = 0;
    m_or   = 0;
    m_head = '0;
    m_x    = START_X;
    m_y    = START_Y;
    m_ir   = IR_OFF;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_reset();
    drive_balanced();
    cross_line();
    reach_border();
    pivot_in_place();                               // last since it turns the robot off north
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/knight_physics_assert.sv
`timescale 1ns/1ps
`default_nettype none

module knight_physics_assert (
  input wire clk,
  input wire rst_n,
  input wire ir_en,
  input wire lft_ir_n,
  input wire cntr_ir_n,
  input wire rght_ir_n,
  input wire phys_vld
);

  logic [11:0] gap;    // clocks since the last phys_vld, saturating
  logic        seen;   // first pulse gone by

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gap  <= '0;
      seen <= 1'b0;
    end else if (phys_vld) begin
      gap  <= '0;
      seen <= 1'b1;
    end else if (gap != '1) begin
      gap <= gap + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // update pulse and ir gating
  //////////////////////////////////////////////////
  a_one_clock: assert property (@(posedge clk) disable iff (!rst_n) phys_vld |=> !phys_vld)
    else $error("phys_vld high for more than one clock");

  a_spacing: assert property (@(posedge clk) disable iff (!rst_n)
                              (phys_vld && seen) |-> (gap >= 12'd2047))
    else $error("phys_vld pulses closer than one pwm period");

  // emitters off during the cycle, all sensors read high
  a_ir_gate: assert property (@(posedge clk) disable iff (!rst_n)
                              !ir_en |-> (lft_ir_n && cntr_ir_n && rght_ir_n))
    else $error("ir output low while ir_en low");

endmodule

bind knight_physics knight_physics_assert u_check (
  .clk(clk), .rst_n(rst_n), .ir_en(ir_en),
  .lft_ir_n(lft_ir_n), .cntr_ir_n(cntr_ir_n), .rght_ir_n(rght_ir_n),
  .phys_vld(phys_vld)
);

`default_nettype wire

// File: rtl/knight_physics.sv
`timescale 1ns/1ps
`default_nettype none

module knight_physics import knight_pkg::*; (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          lft_pwm1,     // left forward
  input  wire                          lft_pwm2,     // left reverse
  input  wire                          rght_pwm1,
  input  wire                          rght_pwm2,
  input  wire                          ir_en,
  output logic                         lft_ir_n,
  output logic                         cntr_ir_n,
  output logic                         rght_ir_n,
  output pose_t                        pose,
  output logic signed [HEAD_BITS-1:0]  heading,
  output logic                         phys_vld
);

  drive_t    drive;      // measured duties
  logic      duty_vld;
  platform_t plat;       // speeds and heading
  logic      plat_vld;
  ir_t       ir;

  //////////////////////////////////////////////////
  // capture then wheels then board
  //////////////////////////////////////////////////
  pwm_capture u_capture (
    .clk      (clk),
    .rst_n    (rst_n),
    .pwm      ({lft_pwm1, lft_pwm2, rght_pwm1, rght_pwm2}),
    .drive    (drive),
    .duty_vld (duty_vld)
  );

  wheel_dynamics u_wheel (
    .clk      (clk),
    .rst_n    (rst_n),
    .drive    (drive),
    .duty_vld (duty_vld),
    .plat     (plat),
    .plat_vld (plat_vld)
  );

  board_model u_board (
    .clk      (clk),
    .rst_n    (rst_n),
    .plat     (plat),
    .plat_vld (plat_vld),
    .ir_en    (ir_en),
    .pose     (pose),
    .ir       (ir),
    .phys_vld (phys_vld)
  );

  assign lft_ir_n  = ir.lft_n;
  assign cntr_ir_n = ir.cntr_n;
  assign rght_ir_n = ir.rght_n;
  assign heading   = plat.heading;   // settles one clock before phys_vld

endmodule

`default_nettype wire

// File: board_model/board_model.sv
`timescale 1ns/1ps
`default_nettype none

module board_model import knight_pkg::*; (
  input  wire            clk,
  input  wire            rst_n,
  input  wire platform_t plat,
  input  wire            plat_vld,
  input  wire            ir_en,
  output pose_t          pose,
  output ir_t            ir,
  output logic           phys_vld
);

  compass_e                   sector;
  logic signed [OMEGA_BITS:0] omega_sum;   // positive when going forward
  logic [3:0]                 step;        // distance per update
  logic                       moving;      // both wheels forward
  logic                       fast;        // fast enough to see the rails
  logic [POS_BITS-1:0]        x_nxt;
  logic [POS_BITS-1:0]        y_nxt;
  logic [11:0]                lat;         // position across the lane
  logic                       rail_hi;
  logic                       rail_lo;
  logic                       on_line;
  logic                       at_border;
  ir_t                        ir_nxt;
  ir_t                        ir_q;        // sensor levels before the enable

  // centre line windows inside one square
  function automatic logic in_line(input logic [11:0] c);
    return (c > LINE_A_LO && c < LINE_A_HI) || (c > LINE_B_LO && c < LINE_B_HI);
  endfunction

  //////////////////////////////////////////////////
  // compass sector from heading[19:8]
  //////////////////////////////////////////////////
  always_comb begin
    case (plat.heading[19:8]) inside
      [12'h000:12'h048]: sector = north_w;
      [12'hFB8:12'hFFF]: sector = north_e;
      [12'h3B8:12'h448]: sector = west;
      [12'h7B8:12'h7FF]: sector = south_w;
      [12'h800:12'h848]: sector = south_e;
      [12'hBB8:12'hC48]: sector = east;
      default:           sector = skew;     // between lanes
    endcase
  end

  assign omega_sum = $signed({plat.omega_lft[OMEGA_BITS-1], plat.omega_lft})
                   + $signed({plat.omega_rght[OMEGA_BITS-1], plat.omega_rght});
  assign step      = omega_sum[16:13];
  assign moving    = (plat.omega_lft > MOVE_MIN) && (plat.omega_rght > MOVE_MIN);
  assign fast      = (omega_sum > RAIL_SPEED);

  //////////////////////////////////////////////////
  // position update
  //////////////////////////////////////////////////
  always_comb begin
    x_nxt = pose.x;
    y_nxt = pose.y;
    if (moving) begin
      case (sector)
        north_w, north_e: y_nxt = pose.y + POS_BITS'(step);
        south_w, south_e: y_nxt = pose.y - POS_BITS'(step);
        west:             x_nxt = pose.x - POS_BITS'(step);
        east:             x_nxt = pose.x + POS_BITS'(step);
        default:          x_nxt = pose.x;    // skewed robot stays put
      endcase
    end
  end

  //////////////////////////////////////////////////
  // sensors from the new position
  //////////////////////////////////////////////////
  assign lat       = (sector == west || sector == east) ? y_nxt[11:0] : x_nxt[11:0];
  assign rail_hi   = fast && (lat > RAIL_HI);
  assign rail_lo   = fast && (lat < RAIL_LO);
  assign on_line   = in_line(x_nxt[11:0]) || in_line(y_nxt[11:0]);
  assign at_border = (sector == north_w || sector == north_e) && (y_nxt > BORDER_Y);

  always_comb begin
    ir_nxt        = IR_OFF;
    ir_nxt.cntr_n = !on_line;
    if (moving) begin
      case (sector)
        north_w, north_e, west: begin   // high side is on the right
          ir_nxt.rght_n = !rail_hi;
          ir_nxt.lft_n  = !rail_lo;
        end
        south_w, south_e, east: begin   // facing back, sides swap
          ir_nxt.lft_n  = !rail_hi;
          ir_nxt.rght_n = !rail_lo;
        end
        default: ir_nxt.lft_n = 1'b1;
      endcase
    end
    if (at_border) begin
      ir_nxt = IR_ALL;                  // all three see the border
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pose     <= '{x: START_X, y: START_Y};
      ir_q     <= IR_OFF;
      phys_vld <= 1'b0;
    end else begin
      phys_vld <= plat_vld;
      if (plat_vld) begin
        pose <= '{x: x_nxt, y: y_nxt};
        ir_q <= ir_nxt;
      end
    end
  end

  // emitters off means no reflection seen
  always_comb begin
    ir = ir_q;
    if (!ir_en) begin
      ir = IR_OFF;
    end
  end

endmodule

`default_nettype wire

// File: wheel_dynamics/wheel_dynamics.sv
`timescale 1ns/1ps
`default_nettype none

module wheel_dynamics import knight_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  wire drive_t drive,
  input  wire         duty_vld,
  output platform_t   plat,
  output logic        plat_vld
);

  wheel_t                      wheel;     // stage 1 wheel speeds
  logic                        s1_vld;
  logic signed [OMEGA_BITS-1:0] yaw_nxt;  // platform rate from new speeds
  logic signed [HEAD_BITS-1:0]  yaw_w;    // yaw widened for the heading sum
  logic signed [HEAD_BITS-1:0]  head_nxt;

  //////////////////////////////////////////////////
  // one wheel update with drag, friction and clamp
  //////////////////////////////////////////////////
  function automatic logic signed [OMEGA_BITS-1:0] wheel_step(
    input logic [PWM_BITS-1:0]         duty1,
    input logic [PWM_BITS-1:0]         duty2,
    input logic signed [OMEGA_BITS-1:0] omega
  );
    logic signed [PWM_BITS:0]     net;     // forward minus reverse
    logic signed [OMEGA_BITS:0]   wide;    // omega with a guard bit
    logic signed [OMEGA_BITS:0]   net_w;
    logic signed [OMEGA_BITS:0]   acc;     // drive less speed drag
    logic signed [ALPHA_BITS-1:0] alpha;
    logic signed [OMEGA_BITS:0]   sum;
    net   = $signed({1'b0, duty1}) - $signed({1'b0, duty2});
    wide  = {omega[OMEGA_BITS-1], omega};
    net_w = {{(OMEGA_BITS - PWM_BITS){net[PWM_BITS]}}, net};
    acc   = net_w - (wide >>> 4) - (wide >>> 6);  // drag is omega/16 + omega/64

    // saturate to 13 signed bits
    if (acc > 17'sd4095) begin
      alpha = 13'sh0FFF;
    end else if (acc < -17'sd4096) begin
      alpha = 13'sh1000;
    end else begin
      alpha = acc[ALPHA_BITS-1:0];
    end

    if (alpha > FRICTION_BAND || alpha < -FRICTION_BAND) begin
      sum = wide + {{(OMEGA_BITS - ALPHA_BITS + 1){alpha[ALPHA_BITS-1]}}, alpha >>> 3};
      if (sum > OMEGA_MAX) begin
        return OMEGA_BITS'(OMEGA_MAX);
      end else if (sum < -OMEGA_MAX) begin
        return OMEGA_BITS'(-OMEGA_MAX);
      end
      return sum[OMEGA_BITS-1:0];
    end
    return omega - (omega >>> 6);   // friction bleeds speed off
  endfunction

  //////////////////////////////////////////////////
  // stage 1 wheel speeds
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wheel  <= '0;
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= duty_vld;
      if (duty_vld) begin
        wheel.omega_lft  <= wheel_step(drive.lft1, drive.lft2, wheel.omega_lft);
        wheel.omega_rght <= wheel_step(drive.rght1, drive.rght2, wheel.omega_rght);
      end
    end
  end

  //////////////////////////////////////////////////
  // stage 2 yaw rate and heading
  //////////////////////////////////////////////////
  assign yaw_nxt = (wheel.omega_rght >>> 1) - (wheel.omega_lft >>> 1);
  assign yaw_w   = {{(HEAD_BITS - OMEGA_BITS){yaw_nxt[OMEGA_BITS-1]}}, yaw_nxt};

  // gain is about 3/256 of yaw per update
  assign head_nxt = plat.heading + (yaw_w >>> 7) + (yaw_w >>> 8)
                  - (yaw_w >>> 12) - (yaw_w >>> 13) - (yaw_w >>> 14);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      plat     <= '0;          // pointing north, standing still
      plat_vld <= 1'b0;
    end else begin
      plat_vld <= s1_vld;
      if (s1_vld) begin
        plat.omega_lft  <= wheel.omega_lft;    // speeds travel with the heading
        plat.omega_rght <= wheel.omega_rght;
        plat.yaw_rate   <= yaw_nxt;
        plat.heading    <= head_nxt;
      end
    end
  end

endmodule

`default_nettype wire

// File: pwm_capture/pwm_capture.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_capture import knight_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire  [3:0] pwm,       // {lft1, lft2, rght1, rght2}
  output drive_t     drive,
  output logic       duty_vld
);

  logic [PWM_BITS-1:0] per_cnt;        // one counter for all four lines
  logic [PWM_BITS-1:0] high_cnt [4];   // index matches pwm bit
  logic                per_end;        // last clock of the period

  assign per_end = (per_cnt == PWM_BITS'(PWM_PERIOD - 1));

  //////////////////////////////////////////////////
  // period counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      per_cnt <= '0;
    end else begin
      per_cnt <= per_cnt + 1'b1;   // free running, wraps after 2047
    end
  end

  // high time per line, counted over 0..2046 only
  for (genvar i = 0; i < 4; i++) begin : g_chan
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        high_cnt[i] <= '0;
      end else if (per_end) begin
        high_cnt[i] <= '0;                   // fresh count next period
      end else if (pwm[i]) begin
        high_cnt[i] <= high_cnt[i] + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // latch all four duties together
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (per_end) begin
      drive <= '{lft1: high_cnt[3], lft2: high_cnt[2],
                 rght1: high_cnt[1], rght2: high_cnt[0]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      duty_vld <= 1'b0;
    end else begin
      duty_vld <= per_end;   // one clock, lines up with new drive
    end
  end

endmodule

`default_nettype wire

// File: common/knight_pkg.sv
`default_nettype none

package knight_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  localparam int PWM_BITS   = 11;   // duty and period counter
  localparam int ALPHA_BITS = 13;   // saturated wheel acceleration
  localparam int OMEGA_BITS = 16;   // wheel speed and yaw rate
  localparam int HEAD_BITS  = 20;   // integrated heading
  localparam int POS_BITS   = 15;   // board coordinate, 4096 per square

  localparam int PWM_PERIOD = 2048; // clocks per pwm period

  //////////////////////////////////////////////////
  // physics constants
  //////////////////////////////////////////////////
  localparam int OMEGA_MAX     = 32700;  // wheel speed limit
  localparam int FRICTION_BAND = 32;     // torque at or below this only drags
  localparam int MOVE_MIN      = 1000;   // each wheel above this to travel
  localparam int RAIL_SPEED    = 22000;  // speed sum where rails get seen

  // board geometry
  localparam logic [POS_BITS-1:0] START_X  = 15'h2800;  // square 2.5
  localparam logic [POS_BITS-1:0] START_Y  = 15'h2800;
  localparam logic [POS_BITS-1:0] BORDER_Y = 15'h5000;  // north edge of the maze

  localparam logic [11:0] RAIL_HI   = 12'h8F0;  // lateral guardrail limits
  localparam logic [11:0] RAIL_LO   = 12'h710;
  localparam logic [11:0] LINE_A_LO = 12'h3E0;  // first centre line window
  localparam logic [11:0] LINE_A_HI = 12'h460;
  localparam logic [11:0] LINE_B_LO = 12'hBA0;  // second centre line window
  localparam logic [11:0] LINE_B_HI = 12'hC20;

  //////////////////////////////////////////////////
  // buses between the stages
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [PWM_BITS-1:0] lft1;   // left motor forward
    logic [PWM_BITS-1:0] lft2;   // left motor reverse
    logic [PWM_BITS-1:0] rght1;
    logic [PWM_BITS-1:0] rght2;
  } drive_t;

  typedef struct packed {
    logic signed [OMEGA_BITS-1:0] omega_lft;
    logic signed [OMEGA_BITS-1:0] omega_rght;
  } wheel_t;

  typedef struct packed {
    logic signed [OMEGA_BITS-1:0] omega_lft;
    logic signed [OMEGA_BITS-1:0] omega_rght;
    logic signed [OMEGA_BITS-1:0] yaw_rate;   // platform turn rate
    logic signed [HEAD_BITS-1:0]  heading;    // zero is north
  } platform_t;

  typedef struct packed {
    logic [POS_BITS-1:0] x;
    logic [POS_BITS-1:0] y;
  } pose_t;

  typedef struct packed {
    logic lft_n;
    logic cntr_n;
    logic rght_n;
  } ir_t;

  localparam ir_t IR_OFF = '{lft_n: 1'b1, cntr_n: 1'b1, rght_n: 1'b1};  // nothing seen
  localparam ir_t IR_ALL = '{lft_n: 1'b0, cntr_n: 1'b0, rght_n: 1'b0};  // border hit

  // heading sectors the board knows how to move in
  typedef enum logic [2:0] {
    north_w,
    north_e,
    south_w,
    south_e,
    west,
    east,
    skew
  } compass_e;

endpackage

`default_nettype wire
